// ==== midi_cc_decoder.sv ====
module midi_cc_decoder (
    input  logic                        read,
    input  logic                        reset_data_N,
    input  logic [3:0]                  midi_channel,
    input  logic                        midi_valid,
    input  logic [7:0]                  midi_byte,
    output synth_msg_pkg::param_write_t wr,
    output logic                        wr_valid
);

    import synth_param_pkg::*;
    import synth_msg_pkg::*;

    cc_state_e          state;
    param_bank_e        cur_bank;
    logic [ADR_W-1:0]   cur_adr;
    logic [6:0]         ctrl;

    logic               is_status;
    logic               is_our_cc;
    logic               take_ctrl;
    logic               take_value;

    // bit 7 marks a status byte
    assign is_status = midi_valid && midi_byte[7];
    assign is_our_cc = (midi_byte[7:4] == 4'hB) && (midi_byte[3:0] == midi_channel);
    assign take_ctrl = midi_valid && !midi_byte[7] && (state == WAIT_CTRL);
    assign take_value = midi_valid && !midi_byte[7] && (state == WAIT_VALUE);

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            state <= WAIT_STATUS;
            cur_bank <= BANK_OSC;
            cur_adr <= '0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            if (is_status) begin
                // foreign status disarms until the next matching CC status
                state <= is_our_cc ? WAIT_CTRL : WAIT_STATUS;
            end else if (take_ctrl) begin
                state <= WAIT_VALUE;
            end else if (take_value) begin
                // running status lets the next pair skip the status byte
                state <= WAIT_CTRL;
                case (ctrl)
                    CC_BANK: begin
                        cur_bank <= param_bank_e'(midi_byte[1:0]);
                    end
                    CC_ADR: begin
                        cur_adr <= midi_byte[6:0];
                    end
                    CC_DATA: begin
                        wr_valid <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // controller number and write payload
    always_ff @(posedge read) begin
        if (take_ctrl) begin
            ctrl <= midi_byte[6:0];
        end
        if (take_value && (ctrl == CC_DATA)) begin
            wr.bank <= cur_bank;
            wr.adr <= cur_adr;
            wr.data <= {1'b0, midi_byte[6:0]};
        end
    end

    // every write needs its own value byte, so pulses never touch
    a_wr_single_pulse: assert property (
        @(posedge read) disable iff (!reset_data_N)
        wr_valid |=> !wr_valid
    );

endmodule

// ==== patch_param_store.sv ====
module patch_param_store (
    input  logic                        read,
    input  logic                        reset_data_N,
    input  synth_msg_pkg::param_write_t wr,
    input  logic                        wr_valid,
    input  synth_msg_pkg::param_read_t  rd_req,
    input  logic                        rd_valid,
    output logic signed [7:0]           rd_data,
    output logic                        rd_readable,
    output synth_msg_pkg::voice_param_t voice
);

    import synth_param_pkg::*;

    logic [7:0]         patch_name [NAME_LEN];
    logic signed [7:0]  mat_buf1 [MAT_SIZE];
    logic signed [7:0]  mat_buf2 [MAT_SIZE];

    logic [OSC_IDX_W-1:0]   wr_osc;
    logic [OFS_W-1:0]       wr_ofs;
    logic [OSC_IDX_W-1:0]   rd_osc;
    logic [OFS_W-1:0]       rd_ofs;
    logic                   wr_in_name;
    logic                   wr_in_mat;

    logic                   rd_ok;
    logic signed [7:0]      rd_val;

    assign wr_osc = wr.adr[ADR_W-1:OFS_W];
    assign wr_ofs = wr.adr[OFS_W-1:0];
    assign rd_osc = rd_req.adr[ADR_W-1:OFS_W];
    assign rd_ofs = rd_req.adr[OFS_W-1:0];

    assign wr_in_name = (wr.adr >= COM_ADR_NAME) && (wr.adr < COM_ADR_END);
    assign wr_in_mat = (wr.adr < MAT_ADR_END);

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            for (int i = 0; i < V_OSC; i++) begin
                // only the first two oscillators sound after reset
                voice.osc[i].level <= (i < 2) ? DEF_LVL_ON : 8'sh00;
                voice.osc[i].mod_out <= '0;
                voice.osc[i].feedb_out <= '0;
                voice.osc[i].pan <= DEF_PAN;
                voice.osc[i].mod_in <= '0;
                voice.osc[i].feedb_in <= '0;
            end
            voice.m_vol <= DEF_VOL;
            for (int n = 0; n < NAME_LEN; n++) begin
                patch_name[n] <= DEF_NAME_CHAR;
            end
            for (int m = 0; m < MAT_SIZE; m++) begin
                mat_buf1[m] <= '0;
                mat_buf2[m] <= '0;
            end
        end else if (wr_valid) begin
            case (wr.bank)
                BANK_OSC: begin
                    for (int i = 0; i < V_OSC; i++) begin
                        if (wr_osc == OSC_IDX_W'(i)) begin
                            case (wr_ofs)
                                OSC_ADR_LVL:       voice.osc[i].level <= wr.data;
                                OSC_ADR_MOD_OUT:   voice.osc[i].mod_out <= wr.data;
                                OSC_ADR_FEEDB_OUT: voice.osc[i].feedb_out <= wr.data;
                                OSC_ADR_PAN:       voice.osc[i].pan <= wr.data;
                                OSC_ADR_MOD_IN:    voice.osc[i].mod_in <= wr.data;
                                OSC_ADR_FEEDB_IN:  voice.osc[i].feedb_in <= wr.data;
                                default: ;
                            endcase
                        end
                    end
                end
                BANK_COM: begin
                    if (wr.adr == COM_ADR_VOL) begin
                        voice.m_vol <= wr.data;
                    end else if (wr_in_name) begin
                        // name base is 16-aligned
                        patch_name[wr.adr[3:0]] <= wr.data;
                    end
                end
                BANK_MAT1: begin
                    if (wr_in_mat) begin
                        mat_buf1[wr.adr[MAT_AW-1:0]] <= wr.data;
                    end
                end
                BANK_MAT2: begin
                    if (wr_in_mat) begin
                        mat_buf2[wr.adr[MAT_AW-1:0]] <= wr.data;
                    end
                end
                default: ;
            endcase
        end
    end

    // read mux and readable rule
    always_comb begin
        rd_ok = 1'b0;
        rd_val = '0;
        case (rd_req.bank)
            BANK_OSC: begin
                for (int i = 0; i < V_OSC; i++) begin
                    if (rd_osc == OSC_IDX_W'(i)) begin
                        rd_ok = 1'b1;
                        case (rd_ofs)
                            OSC_ADR_LVL:       rd_val = voice.osc[i].level;
                            OSC_ADR_MOD_OUT:   rd_val = voice.osc[i].mod_out;
                            OSC_ADR_FEEDB_OUT: rd_val = voice.osc[i].feedb_out;
                            OSC_ADR_PAN:       rd_val = voice.osc[i].pan;
                            OSC_ADR_MOD_IN:    rd_val = voice.osc[i].mod_in;
                            OSC_ADR_FEEDB_IN:  rd_val = voice.osc[i].feedb_in;
                            default:           rd_ok = (rd_ofs >= OSC_ADR_ZERO);
                        endcase
                    end
                end
            end
            BANK_COM: begin
                if (rd_req.adr == COM_ADR_VOL) begin
                    rd_ok = 1'b1;
                    rd_val = voice.m_vol;
                end else if ((rd_req.adr >= COM_ADR_NAME) && (rd_req.adr < COM_ADR_END)) begin
                    rd_ok = 1'b1;
                    rd_val = patch_name[rd_req.adr[3:0]];
                end else if (rd_req.adr >= COM_ADR_ZERO && rd_req.adr < COM_ADR_NAME) begin
                    rd_ok = 1'b1;
                end
            end
            BANK_MAT1: begin
                rd_ok = (rd_req.adr < MAT_ADR_END);
                rd_val = mat_buf1[rd_req.adr[MAT_AW-1:0]];
            end
            BANK_MAT2: begin
                rd_ok = (rd_req.adr < MAT_ADR_END);
                rd_val = mat_buf2[rd_req.adr[MAT_AW-1:0]];
            end
            default: ;
        endcase
    end

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            rd_readable <= 1'b0;
        end else begin
            rd_readable <= rd_valid && rd_ok;
        end
    end

    always_ff @(posedge read) begin
        rd_data <= rd_val;
    end

    // a reply only ever answers the request of the cycle before
    a_reply_follows_req: assert property (
        @(posedge read) disable iff (!reset_data_N)
        rd_readable |-> $past(rd_valid)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_synth_param \
    -f synth_param.f -o sim_tb_synth_param > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_tb_synth_param > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1

// ==== synth_msg_pkg.sv ====
package synth_msg_pkg;

    // decoder -> store
    typedef struct packed {
        synth_param_pkg::param_bank_e           bank;
        logic [synth_param_pkg::ADR_W-1:0]      adr;
        logic signed [7:0]                      data;
    } param_write_t;

    // dump engine -> store
    typedef struct packed {
        synth_param_pkg::param_bank_e           bank;
        logic [synth_param_pkg::ADR_W-1:0]      adr;
    } param_read_t;

    // one entry of a patch dump
    typedef struct packed {
        synth_param_pkg::param_bank_e           bank;
        logic [synth_param_pkg::ADR_W-1:0]      adr;
        logic signed [7:0]                      value;
    } dump_item_t;

    typedef struct packed {
        logic signed [7:0] level;
        logic signed [7:0] mod_out;
        logic signed [7:0] feedb_out;
        logic signed [7:0] pan;
        logic signed [7:0] mod_in;
        logic signed [7:0] feedb_in;
    } osc_param_t;

    // live settings to the synthesis engine
    typedef struct packed {
        osc_param_t [synth_param_pkg::V_OSC-1:0] osc;
        logic signed [7:0]                       m_vol;
    } voice_param_t;

    typedef enum logic [1:0] {
        WAIT_STATUS = 2'd0,
        WAIT_CTRL   = 2'd1,
        WAIT_VALUE  = 2'd2
    } cc_state_e;

endpackage

// ==== synth_param.f ====
synth_param_pkg.sv
synth_msg_pkg.sv
midi_cc_decoder.sv
patch_param_store.sv
sysex_dump_engine.sv
synth_param_top.sv
tb_synth_param.sv

// ==== synth_param_pkg.sv ====
package synth_param_pkg;

    // voice size
    localparam int V_OSC = 4;

    localparam int ADR_W = 7;
    // upper address bits select the oscillator block, low four the offset
    localparam int OFS_W = 4;
    localparam int OSC_IDX_W = ADR_W - OFS_W;

    localparam int NAME_LEN = 16;
    localparam int MAT_SIZE = 16 * V_OSC;
    localparam int MAT_AW = $clog2(MAT_SIZE);

    typedef enum logic [1:0] {
        BANK_OSC  = 2'd0,
        BANK_COM  = 2'd1,
        BANK_MAT1 = 2'd2,
        BANK_MAT2 = 2'd3
    } param_bank_e;

    // offsets inside one oscillator block
    localparam logic [OFS_W-1:0] OSC_ADR_LVL       = 4'd2;
    localparam logic [OFS_W-1:0] OSC_ADR_MOD_OUT   = 4'd3;
    localparam logic [OFS_W-1:0] OSC_ADR_FEEDB_OUT = 4'd4;
    localparam logic [OFS_W-1:0] OSC_ADR_PAN       = 4'd7;
    localparam logic [OFS_W-1:0] OSC_ADR_MOD_IN    = 4'd10;
    localparam logic [OFS_W-1:0] OSC_ADR_FEEDB_IN  = 4'd11;
    // 12 to 15 are readable and always zero
    localparam logic [OFS_W-1:0] OSC_ADR_ZERO      = 4'd12;

    // common bank map
    localparam logic [ADR_W-1:0] COM_ADR_VOL  = 7'd1;
    localparam logic [ADR_W-1:0] COM_ADR_ZERO = 7'd10;
    localparam logic [ADR_W-1:0] COM_ADR_NAME = 7'd16;
    localparam logic [ADR_W-1:0] COM_ADR_END  = 7'd32;

    // matrix buffers fill the low 16 * V_OSC addresses
    localparam logic [ADR_W-1:0] MAT_ADR_END = ADR_W'(MAT_SIZE);

    // reset values
    localparam logic signed [7:0] DEF_LVL_ON    = 8'h40;
    localparam logic signed [7:0] DEF_PAN       = 8'h40;
    localparam logic signed [7:0] DEF_VOL       = 8'h40;
    localparam logic [7:0]        DEF_NAME_CHAR = 8'd32;

    // controller numbers
    localparam logic [6:0] CC_BANK = 7'h63;
    localparam logic [6:0] CC_ADR  = 7'h62;
    localparam logic [6:0] CC_DATA = 7'h06;

endpackage

// ==== synth_param_top.sv ====
module synth_param_top (
    input  logic                         read,
    input  logic                         reset_data_N,
    input  logic [3:0]                   midi_channel,
    input  logic                         midi_valid,
    input  logic [7:0]                   midi_byte,
    input  logic                         dump_start,
    input  synth_param_pkg::param_bank_e dump_bank,
    output synth_msg_pkg::voice_param_t  voice,
    output synth_msg_pkg::dump_item_t    dump_item,
    output logic                         dump_valid,
    output logic                         dump_busy,
    output logic                         dump_done
);

    import synth_msg_pkg::*;

    param_write_t       wr;
    logic               wr_valid;
    param_read_t        rd_req;
    logic               rd_valid;
    logic signed [7:0]  rd_data;
    logic               rd_readable;

    midi_cc_decoder u_decoder (
        .read         (read),
        .reset_data_N (reset_data_N),
        .midi_channel (midi_channel),
        .midi_valid   (midi_valid),
        .midi_byte    (midi_byte),
        .wr           (wr),
        .wr_valid     (wr_valid)
    );

    patch_param_store u_store (
        .read         (read),
        .reset_data_N (reset_data_N),
        .wr           (wr),
        .wr_valid     (wr_valid),
        .rd_req       (rd_req),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_readable  (rd_readable),
        .voice        (voice)
    );

    sysex_dump_engine u_dump (
        .read         (read),
        .reset_data_N (reset_data_N),
        .dump_start   (dump_start),
        .dump_bank    (dump_bank),
        .rd_req       (rd_req),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_readable  (rd_readable),
        .dump_item    (dump_item),
        .dump_valid   (dump_valid),
        .dump_busy    (dump_busy),
        .dump_done    (dump_done)
    );

endmodule

// ==== sysex_dump_engine.sv ====
module sysex_dump_engine (
    input  logic                         read,
    input  logic                         reset_data_N,
    input  logic                         dump_start,
    input  synth_param_pkg::param_bank_e dump_bank,
    output synth_msg_pkg::param_read_t   rd_req,
    output logic                         rd_valid,
    input  logic signed [7:0]            rd_data,
    input  logic                         rd_readable,
    output synth_msg_pkg::dump_item_t    dump_item,
    output logic                         dump_valid,
    output logic                         dump_busy,
    output logic                         dump_done
);

    import synth_param_pkg::*;

    typedef enum logic [1:0] {
        DUMP_IDLE  = 2'd0,
        DUMP_SCAN  = 2'd1,
        DUMP_FLUSH = 2'd2
    } dump_state_e;

    dump_state_e        state;
    param_bank_e        bank_q;
    logic [ADR_W-1:0]   adr_cnt;
    logic               inflight;
    logic [ADR_W-1:0]   inflight_adr;

    assign rd_valid = (state == DUMP_SCAN);
    assign rd_req.bank = bank_q;
    assign rd_req.adr = adr_cnt;
    assign dump_busy = (state != DUMP_IDLE);

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            state <= DUMP_IDLE;
            adr_cnt <= '0;
            inflight <= 1'b0;
            dump_valid <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            inflight <= rd_valid;
            dump_valid <= inflight && rd_readable;
            dump_done <= 1'b0;
            case (state)
                DUMP_IDLE: begin
                    if (dump_start) begin
                        state <= DUMP_SCAN;
                        adr_cnt <= '0;
                    end
                end
                DUMP_SCAN: begin
                    adr_cnt <= adr_cnt + 1'b1;
                    if (adr_cnt == '1) begin
                        state <= DUMP_FLUSH;
                    end
                end
                DUMP_FLUSH: begin
                    // wait until the last reply has gone out
                    if (!inflight) begin
                        state <= DUMP_IDLE;
                        dump_done <= 1'b1;
                    end
                end
                default: state <= DUMP_IDLE;
            endcase
        end
    end

    // bank latch, address tag of the reply and the emitted item
    always_ff @(posedge read) begin
        if (state == DUMP_IDLE && dump_start) begin
            bank_q <= dump_bank;
        end
        inflight_adr <= adr_cnt;
        if (inflight && rd_readable) begin
            dump_item.bank <= bank_q;
            dump_item.adr <= inflight_adr;
            dump_item.value <= rd_data;
        end
    end

    a_item_inside_busy: assert property (
        @(posedge read) disable iff (!reset_data_N)
        dump_valid |-> dump_busy
    );

endmodule

// ==== tb_synth_param.sv ====
module tb_synth_param;

    import synth_param_pkg::*;
    import synth_msg_pkg::*;

    logic           read;
    logic           reset_data_N;
    logic [3:0]     midi_channel;
    logic           midi_valid;
    logic [7:0]     midi_byte;
    logic           dump_start;
    param_bank_e    dump_bank;
    voice_param_t   voice;
    dump_item_t     dump_item;
    logic           dump_valid;
    logic           dump_busy;
    logic           dump_done;

    int             errors;
    int             checks;
    logic [31:0]    rng;
    // expected contents of all four banks
    logic signed [7:0] mdl [4][128];

    synth_param_top UUT (.*);

    initial begin
        read = 1'b0;
        forever #5 read = ~read;
    end

    function automatic logic [6:0] next_rand7();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng[6:0];
    endfunction

    function automatic bit is_register(param_bank_e bank, int adr);
        int ofs;
        ofs = adr % 16;
        case (bank)
            BANK_OSC: return (adr < 16 * V_OSC) && (ofs inside {2, 3, 4, 7, 10, 11});
            BANK_COM: return (adr == 1) || (adr >= 16 && adr < 32);
            default:  return adr < 16 * V_OSC;
        endcase
    endfunction

    function automatic bit is_readable(param_bank_e bank, int adr);
        int ofs;
        ofs = adr % 16;
        case (bank)
            BANK_OSC: return (adr < 16 * V_OSC) && ((ofs inside {2, 3, 4, 7}) || ofs >= 10);
            BANK_COM: return (adr == 1) || (adr >= 10 && adr < 32);
            default:  return adr < 16 * V_OSC;
        endcase
    endfunction

    task automatic reset_model();
        for (int b = 0; b < 4; b++) begin
            for (int a = 0; a < 128; a++) begin
                mdl[b][a] = 8'sh00;
            end
        end
        for (int i = 0; i < V_OSC; i++) begin
            mdl[0][i * 16 + 2] = (i < 2) ? 8'sh40 : 8'sh00;
            mdl[0][i * 16 + 7] = 8'sh40;
        end
        mdl[1][1] = 8'sh40;
        // name starts as spaces
        for (int k = 16; k < 32; k++) begin
            mdl[1][k] = 8'sd32;
        end
    endtask

    function automatic voice_param_t model_voice();
        voice_param_t v;
        v = '0;
        for (int i = 0; i < V_OSC; i++) begin
            v.osc[i].level = mdl[0][i * 16 + 2];
            v.osc[i].mod_out = mdl[0][i * 16 + 3];
            v.osc[i].feedb_out = mdl[0][i * 16 + 4];
            v.osc[i].pan = mdl[0][i * 16 + 7];
            v.osc[i].mod_in = mdl[0][i * 16 + 10];
            v.osc[i].feedb_in = mdl[0][i * 16 + 11];
        end
        v.m_vol = mdl[1][1];
        return v;
    endfunction

    task automatic check_voice(input voice_param_t got, input voice_param_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: voice after %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_dump_item(input dump_item_t got, input dump_item_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: dump item got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge read);
        midi_valid <= 1'b1;
        midi_byte <= b;
        @(posedge read);
        midi_valid <= 1'b0;
    endtask

    task automatic send_pair(input logic [6:0] ctrl, input logic [6:0] value);
        send_byte({1'b0, ctrl});
        send_byte({1'b0, value});
    endtask

    task automatic send_cc(input logic [3:0] chan, input logic [6:0] ctrl,
                           input logic [6:0] value);
        send_byte({4'hB, chan});
        send_pair(ctrl, value);
    endtask

    // write pulse, then the store edge, then a stable sample point
    task automatic finish_write();
        @(posedge read);
        @(negedge read);
    endtask

    task automatic write_param(input param_bank_e bank, input int adr, input logic [6:0] value);
        send_cc(midi_channel, CC_BANK, 7'(bank));
        send_pair(CC_ADR, 7'(adr));
        send_pair(CC_DATA, value);
        if (is_register(bank, adr)) begin
            mdl[int'(bank)][adr] = {1'b0, value};
        end
        finish_write();
    endtask

    task automatic run_dump(input param_bank_e bank, input int poke_cycle);
        int         exp_q[$];
        int         count;
        bit         done;
        dump_item_t exp;
        for (int a = 0; a < 128; a++) begin
            if (is_readable(bank, a)) begin
                exp_q.push_back(a);
            end
        end
        count = exp_q.size();
        done = 1'b0;
        @(posedge read);
        dump_start <= 1'b1;
        dump_bank <= bank;
        for (int i = 0; i < 400 && !done; i++) begin
            @(posedge read);
            // optional restart attempt while the scan runs
            dump_start <= (i == poke_cycle);
            @(negedge read);
            if (dump_valid && exp_q.size() == 0) begin
                errors++;
                $display("dump of bank %s sent more items than expected", bank.name());
            end else if (dump_valid) begin
                exp.bank = bank;
                exp.adr = 7'(exp_q[0]);
                exp.value = mdl[int'(bank)][exp_q[0]];
                check_dump_item(dump_item, exp);
                void'(exp_q.pop_front());
            end
            done = dump_done;
        end
        if (!done) begin
            errors++;
            $display("dump of bank %s never signalled dump_done", bank.name());
        end else if (exp_q.size() != 0) begin
            errors++;
            $display("dump of bank %s gave %0d items instead of %0d", bank.name(),
                     count - exp_q.size(), count);
        end else if (dump_busy) begin
            errors++;
            $display("dump_busy still high when dump_done pulsed");
        end
    endtask

    task automatic reset_defaults();
        check_voice(voice, model_voice(), "reset");
        run_dump(BANK_COM, -1);
    endtask

    task automatic osc_field_writes();
        int ofs_list[6] = '{2, 3, 4, 7, 10, 11};
        for (int i = 0; i < V_OSC; i++) begin
            for (int k = 0; k < 6; k++) begin
                write_param(BANK_OSC, i * 16 + ofs_list[k], next_rand7());
                check_voice(voice, model_voice(), "oscillator write");
            end
        end
        for (int k = 12; k < 16; k++) begin
            write_param(BANK_OSC, 16 + k, next_rand7());
            check_voice(voice, model_voice(), "write to a zero offset");
        end
    endtask

    task automatic channel_and_running_status();
        logic [3:0] other;
        logic [6:0] v1;
        logic [6:0] v2;
        other = midi_channel + 4'd1;
        send_cc(other, CC_BANK, 7'(BANK_COM));
        send_pair(CC_ADR, 7'd1);
        send_pair(CC_DATA, 7'h11);
        finish_write();
        check_voice(voice, model_voice(), "foreign channel");
        v1 = next_rand7();
        v2 = next_rand7();
        // one status byte, then running status pairs
        send_cc(midi_channel, CC_BANK, 7'(BANK_OSC));
        send_pair(CC_ADR, 7'd34);
        send_pair(CC_DATA, v1);
        send_pair(CC_ADR, 7'd39);
        send_pair(CC_DATA, v2);
        mdl[0][34] = {1'b0, v1};
        mdl[0][39] = {1'b0, v2};
        finish_write();
        check_voice(voice, model_voice(), "running status");
        send_byte({4'h9, midi_channel});
        send_pair(CC_ADR, 7'd34);
        send_pair(CC_DATA, next_rand7());
        finish_write();
        check_voice(voice, model_voice(), "note-on status");
    endtask

    task automatic fill_matrix(input param_bank_e bank);
        for (int a = 0; a < 16 * V_OSC; a++) begin
            write_param(bank, a, next_rand7());
        end
        write_param(bank, 100, next_rand7());
    endtask

    task automatic matrix_roundtrip();
        fill_matrix(BANK_MAT1);
        fill_matrix(BANK_MAT2);
        run_dump(BANK_MAT1, -1);
        run_dump(BANK_MAT2, -1);
    endtask

    task automatic osc_readable_map();
        run_dump(BANK_OSC, -1);
    endtask

    task automatic name_and_busy();
        string name = "FM BRASS PATCH 1";
        for (int k = 0; k < 16; k++) begin
            write_param(BANK_COM, 16 + k, 7'(name[k]));
        end
        write_param(BANK_COM, 1, next_rand7());
        check_voice(voice, model_voice(), "master volume write");
        run_dump(BANK_COM, 20);
    endtask

    initial begin
        rng = 32'd38458;
        errors = 0;
        checks = 0;
        reset_data_N = 1'b0;
        midi_channel = 4'd5;
        midi_valid = 1'b0;
        midi_byte = 8'h00;
        dump_start = 1'b0;
        dump_bank = BANK_OSC;
        reset_model();
        repeat (10) @(posedge read);
        reset_data_N <= 1'b1;
        @(negedge read);
        reset_defaults();
        osc_field_writes();
        channel_and_running_status();
        matrix_roundtrip();
        osc_readable_map();
        name_and_busy();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
